// File: src/stm_pkg.sv
// STM debug NoC package
// Flit and trace word types, flit type codes and header layout
// NoC classes, host address and configuration register map
`default_nettype none

package stm_pkg;

   // One debug NoC flit, type code in the top two bits
   typedef struct packed {
      logic [1:0]  ftype;
      logic [15:0] data;
   } flit_t;

   // Trace word as delivered by the core
   typedef struct packed {
      logic [31:0] timestamp;
      logic [31:0] reg_value;
      logic [15:0] insn;
   } trace_t;

   // Header flit data field
   typedef struct packed {
      logic [4:0] dest;
      logic [2:0] cls;
      logic [7:0] id;
   } hdr_t;

   // Flit type codes
   localparam logic [1:0] FLIT_PAYLOAD = 2'd0;
   localparam logic [1:0] FLIT_HEADER  = 2'd1;
   localparam logic [1:0] FLIT_LAST    = 2'd2;

   // Packet classes
   localparam logic [2:0] CLASS_CONF_REQ  = 3'd1;
   localparam logic [2:0] CLASS_CONF_RESP = 3'd2;
   localparam logic [2:0] CLASS_TRACE     = 3'd3;

   // All outgoing packets go to the host
   localparam logic [4:0] ADDR_HOST = 5'd0;

   // Module identification
   localparam logic [7:0] MODULE_TYPE_STM    = 8'h05;
   localparam logic [7:0] MODULE_VERSION_STM = 8'h00;

   // Read-only register addresses
   localparam logic [15:0] REG_TYPE_VERSION = 16'd0;
   localparam logic [15:0] REG_CORE_ID      = 16'd1;
   localparam logic [15:0] REG_TRACE_COUNT  = 16'd2;

endpackage

`default_nettype wire

// File: src/flit_fifo.sv
// Synchronous valid/ready FIFO
// Register array, payload type and depth set by parameters
`default_nettype none
`timescale 1ns/100ps

module flit_fifo #(
   parameter type payload_t = logic [17:0],
   parameter int  DEPTH     = 4
) (
   input  wire      clk,
   input  wire      rst,
   input  payload_t in_data,
   input  wire      in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  wire      out_ready
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   // Pointer step with wrap, depth need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign in_ready  = (count != CNT_W'(DEPTH));
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];

   assign push = in_valid & in_ready;
   assign pop  = out_valid & out_ready;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         // Fill level, unchanged on push and pop together
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: src/trace_capture.sv
// Trace input side
// Trace word queue and registered system clock disable
`default_nettype none
`timescale 1ns/100ps

module trace_capture import stm_pkg::*; #(
   parameter int TRACE_DEPTH = 4
) (
   input  wire    clk,
   input  wire    rst,
   input  trace_t trace_in,
   input  wire    trace_in_valid,
   output logic   sys_clk_disable,
   output trace_t word,
   output logic   word_valid,
   input  wire    word_ready
);

   logic queue_ready;

   // Core has no ready, a word offered to a full queue is dropped
   flit_fifo #(
      .payload_t (trace_t),
      .DEPTH     (TRACE_DEPTH)
   ) u_trace_fifo (
      .clk       (clk),
      .rst       (rst),
      .in_data   (trace_in),
      .in_valid  (trace_in_valid),
      .in_ready  (queue_ready),
      .out_data  (word),
      .out_valid (word_valid),
      .out_ready (word_ready)
   );

   // Halt the core while the queue is full
   always_ff @(posedge clk) begin
      if (rst) begin
         sys_clk_disable <= 1'b0;
      end else begin
         sys_clk_disable <= ~queue_ready;
      end
   end

endmodule

`default_nettype wire

// File: src/trace_packetizer.sv
// Trace packetizer
// FSM cutting each trace word into a six-flit packet
// One-cycle packet_sent pulse after each last flit
`default_nettype none
`timescale 1ns/100ps

module trace_packetizer import stm_pkg::*; #(
   parameter logic [7:0] CORE_ID = 8'h00
) (
   input  wire    clk,
   input  wire    rst,
   input  trace_t word,
   input  wire    word_valid,
   output logic   word_ready,
   output flit_t  flit,
   output logic   flit_valid,
   input  wire    flit_ready,
   output logic   packet_sent
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_HEADER,
      S_TS_MSB,
      S_TS_LSB,
      S_REG_MSB,
      S_REG_LSB,
      S_INSN
   } state_t;

   state_t state;
   state_t step_state;
   trace_t trace_buf;
   hdr_t   hdr;

   assign hdr = '{dest: ADDR_HOST, cls: CLASS_TRACE, id: CORE_ID};

   // Only take a new word between packets
   assign word_ready = (state == S_IDLE);
   assign flit_valid = (state != S_IDLE);

   // Flit on offer and the state after it is accepted
   always_comb begin
      flit       = '0;
      step_state = S_IDLE;
      case (state)
         S_HEADER: begin
            flit       = '{ftype: FLIT_HEADER, data: hdr};
            step_state = S_TS_MSB;
         end
         S_TS_MSB: begin
            flit       = '{ftype: FLIT_PAYLOAD, data: trace_buf.timestamp[31:16]};
            step_state = S_TS_LSB;
         end
         S_TS_LSB: begin
            flit       = '{ftype: FLIT_PAYLOAD, data: trace_buf.timestamp[15:0]};
            step_state = S_REG_MSB;
         end
         S_REG_MSB: begin
            flit       = '{ftype: FLIT_PAYLOAD, data: trace_buf.reg_value[31:16]};
            step_state = S_REG_LSB;
         end
         S_REG_LSB: begin
            flit       = '{ftype: FLIT_PAYLOAD, data: trace_buf.reg_value[15:0]};
            step_state = S_INSN;
         end
         // Instruction word closes the packet
         S_INSN: begin
            flit       = '{ftype: FLIT_LAST, data: trace_buf.insn};
            step_state = S_IDLE;
         end
         default: begin
            flit       = '0;
            step_state = S_IDLE;
         end
      endcase
   end

   // Word buffer, held for the whole packet
   always_ff @(posedge clk) begin
      if (word_valid && word_ready) begin
         trace_buf <= word;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= S_IDLE;
         packet_sent <= 1'b0;
      end else begin
         packet_sent <= 1'b0;
         if (state == S_IDLE) begin
            if (word_valid) begin
               state <= S_HEADER;
            end
         end else if (flit_ready) begin
            // Advance only on accept, flit held under back-pressure
            state       <= step_state;
            packet_sent <= (state == S_INSN);
         end
      end
   end

endmodule

`default_nettype wire

// File: src/conf_responder.sv
// Configuration responder
// Parses read request packets, answers with two-flit responses
// Read-only registers: type/version, core id, trace packet count
`default_nettype none
`timescale 1ns/100ps

module conf_responder import stm_pkg::*; #(
   parameter logic [7:0] CORE_ID = 8'h00
) (
   input  wire   clk,
   input  wire   rst,
   input  flit_t in_flit,
   input  wire   in_valid,
   output logic  in_ready,
   output flit_t resp_flit,
   output logic  resp_valid,
   input  wire   resp_ready,
   input  wire   packet_sent
);

   typedef enum logic [2:0] {
      S_RX_HDR,
      S_RX_ADDR,
      S_RX_DROP,
      S_TX_HDR,
      S_TX_DATA
   } state_t;

   state_t      state;
   hdr_t        in_hdr;
   hdr_t        resp_hdr;
   logic [15:0] trace_count;
   logic [15:0] rd_mux;
   logic [15:0] rd_data;
   logic        in_fire;
   logic        resp_fire;

   assign in_hdr   = hdr_t'(in_flit.data);
   assign resp_hdr = '{dest: ADDR_HOST, cls: CLASS_CONF_RESP, id: CORE_ID};

   // Input stalls while a response is pending
   assign in_ready   = (state == S_RX_HDR) || (state == S_RX_ADDR) || (state == S_RX_DROP);
   assign resp_valid = (state == S_TX_HDR) || (state == S_TX_DATA);

   assign in_fire   = in_valid & in_ready;
   assign resp_fire = resp_valid & resp_ready;

   // Register read, addressed by the incoming address flit
   always_comb begin
      case (in_flit.data)
         REG_TYPE_VERSION: rd_mux = {MODULE_TYPE_STM, MODULE_VERSION_STM};
         REG_CORE_ID:      rd_mux = {8'h00, CORE_ID};
         REG_TRACE_COUNT:  rd_mux = trace_count;
         default:          rd_mux = 16'h0000;
      endcase
   end

   always_comb begin
      case (state)
         S_TX_HDR:  resp_flit = '{ftype: FLIT_HEADER, data: resp_hdr};
         S_TX_DATA: resp_flit = '{ftype: FLIT_LAST, data: rd_data};
         default:   resp_flit = '0;
      endcase
   end

   // Read value captured with the address
   always_ff @(posedge clk) begin
      if (in_fire && state == S_RX_ADDR && in_flit.ftype == FLIT_LAST) begin
         rd_data <= rd_mux;
      end
   end

   // Sent trace packets, wraps at 2^16
   always_ff @(posedge clk) begin
      if (rst) begin
         trace_count <= '0;
      end else if (packet_sent) begin
         trace_count <= trace_count + 16'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_RX_HDR;
      end else begin
         case (state)
            S_RX_HDR: begin
               if (in_fire) begin
                  if (in_flit.ftype == FLIT_HEADER && in_hdr.cls == CLASS_CONF_REQ) begin
                     state <= S_RX_ADDR;
                  end else if (in_flit.ftype != FLIT_LAST) begin
                     // Foreign packet, swallow up to its last flit
                     state <= S_RX_DROP;
                  end
               end
            end
            S_RX_ADDR: begin
               if (in_fire) begin
                  // Longer than two flits means not a valid read
                  state <= (in_flit.ftype == FLIT_LAST) ? S_TX_HDR : S_RX_DROP;
               end
            end
            S_RX_DROP: begin
               if (in_fire && in_flit.ftype == FLIT_LAST) begin
                  state <= S_RX_HDR;
               end
            end
            S_TX_HDR: begin
               if (resp_fire) begin
                  state <= S_TX_DATA;
               end
            end
            S_TX_DATA: begin
               if (resp_fire) begin
                  state <= S_RX_HDR;
               end
            end
            default: state <= S_RX_HDR;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: src/noc_out_arbiter.sv
// Output arbiter for the debug NoC port
// Round-robin between trace and response flits, locked per packet
`default_nettype none
`timescale 1ns/100ps

module noc_out_arbiter import stm_pkg::*; (
   input  wire   clk,
   input  wire   rst,
   input  flit_t trace_flit,
   input  wire   trace_valid,
   output logic  trace_ready,
   input  flit_t resp_flit,
   input  wire   resp_valid,
   output logic  resp_ready,
   output flit_t out_flit,
   output logic  out_valid,
   input  wire   out_ready
);

   // Source select encoding
   localparam logic SRC_TRACE = 1'b0;
   localparam logic SRC_RESP  = 1'b1;

   logic  locked;
   logic  lock_sel;
   logic  last_grant;
   logic  sel;
   logic  pkt_done;
   flit_t sel_flit;

   // Grant, held by the lock once a packet is on the port
   always_comb begin
      if (locked) begin
         sel = lock_sel;
      end else if (trace_valid && resp_valid) begin
         sel = ~last_grant;
      end else begin
         sel = resp_valid ? SRC_RESP : SRC_TRACE;
      end
   end

   assign sel_flit  = (sel == SRC_RESP) ? resp_flit : trace_flit;
   assign out_valid = (sel == SRC_RESP) ? resp_valid : trace_valid;
   // Idle port shows a zero flit
   assign out_flit  = out_valid ? sel_flit : '0;

   // Ready only to the granted source
   assign trace_ready = out_ready && (sel == SRC_TRACE);
   assign resp_ready  = out_ready && (sel == SRC_RESP);

   assign pkt_done = out_valid && out_ready && (sel_flit.ftype == FLIT_LAST);

   always_ff @(posedge clk) begin
      if (rst) begin
         locked     <= 1'b0;
         lock_sel   <= SRC_TRACE;
         last_grant <= SRC_TRACE;
      end else if (pkt_done) begin
         // Packet boundary, other source gets priority next
         locked     <= 1'b0;
         last_grant <= sel;
      end else if (out_valid && !locked) begin
         // First flit offered, hold this source even if it stalls
         locked   <= 1'b1;
         lock_sel <= sel;
      end
   end

endmodule

`default_nettype wire

// File: src/stm_dbgnoc_top.sv
// STM debug NoC interface top level
// Trace capture, packetizer, output flit FIFO, responder, arbiter
`default_nettype none
`timescale 1ns/100ps

module stm_dbgnoc_top import stm_pkg::*; #(
   parameter logic [7:0] CORE_ID     = 8'h00,
   parameter int         TRACE_DEPTH = 4,
   parameter int         OUT_DEPTH   = 6
) (
   input  wire    clk,
   input  wire    rst,
   input  trace_t trace_in,
   input  wire    trace_in_valid,
   output logic   sys_clk_disable,
   output flit_t  dbgnoc_out_flit,
   output logic   dbgnoc_out_valid,
   input  wire    dbgnoc_out_ready,
   input  flit_t  dbgnoc_in_flit,
   input  wire    dbgnoc_in_valid,
   output logic   dbgnoc_in_ready
);

   // Queue to packetizer
   trace_t word;
   logic   word_valid;
   logic   word_ready;
   // Packetizer to output FIFO
   flit_t  pk_flit;
   logic   pk_valid;
   logic   pk_ready;
   // Output FIFO to arbiter
   flit_t  trace_flit;
   logic   trace_valid;
   logic   trace_ready;
   // Responder to arbiter
   flit_t  resp_flit;
   logic   resp_valid;
   logic   resp_ready;
   logic   packet_sent;

   trace_capture #(.TRACE_DEPTH(TRACE_DEPTH)) u_trace_capture (
      .clk(clk), .rst(rst), .trace_in(trace_in), .trace_in_valid(trace_in_valid),
      .sys_clk_disable(sys_clk_disable), .word(word), .word_valid(word_valid),
      .word_ready(word_ready)
   );

   trace_packetizer #(.CORE_ID(CORE_ID)) u_trace_packetizer (
      .clk(clk), .rst(rst), .word(word), .word_valid(word_valid), .word_ready(word_ready),
      .flit(pk_flit), .flit_valid(pk_valid), .flit_ready(pk_ready),
      .packet_sent(packet_sent)
   );

   // Holds one full trace packet
   flit_fifo #(.payload_t(flit_t), .DEPTH(OUT_DEPTH)) u_out_fifo (
      .clk(clk), .rst(rst), .in_data(pk_flit), .in_valid(pk_valid), .in_ready(pk_ready),
      .out_data(trace_flit), .out_valid(trace_valid), .out_ready(trace_ready)
   );

   conf_responder #(.CORE_ID(CORE_ID)) u_conf_responder (
      .clk(clk), .rst(rst), .in_flit(dbgnoc_in_flit), .in_valid(dbgnoc_in_valid),
      .in_ready(dbgnoc_in_ready), .resp_flit(resp_flit), .resp_valid(resp_valid),
      .resp_ready(resp_ready), .packet_sent(packet_sent)
   );

   noc_out_arbiter u_noc_out_arbiter (
      .clk(clk), .rst(rst), .trace_flit(trace_flit), .trace_valid(trace_valid),
      .trace_ready(trace_ready), .resp_flit(resp_flit), .resp_valid(resp_valid),
      .resp_ready(resp_ready), .out_flit(dbgnoc_out_flit), .out_valid(dbgnoc_out_valid),
      .out_ready(dbgnoc_out_ready)
   );

endmodule

`default_nettype wire

// File: tests/stm_assert.sv
// Concurrent assertions on the STM debug NoC top-level ports
// Output stability under back-pressure, known outputs, reset values
`default_nettype none
`timescale 1ns/100ps

module stm_assert import stm_pkg::*; (
   input wire   clk,
   input wire   rst,
   input wire   sys_clk_disable,
   input flit_t dbgnoc_out_flit,
   input wire   dbgnoc_out_valid,
   input wire   dbgnoc_out_ready,
   input wire   dbgnoc_in_ready
);

   // Offered flit held until the host takes it
   a_out_stable: assert property (@(posedge clk) disable iff (rst)
      dbgnoc_out_valid && !dbgnoc_out_ready |=> dbgnoc_out_valid && $stable(dbgnoc_out_flit))
      else $error("outgoing flit or valid changed under back-pressure");

   // No X or Z on the outputs once out of reset
   a_known: assert property (@(posedge clk) disable iff (rst)
      !$isunknown({sys_clk_disable, dbgnoc_out_valid, dbgnoc_out_flit, dbgnoc_in_ready}))
      else $error("unknown value on a top-level output");

   // Synchronous reset, cleared one edge after rst is seen
   a_reset_low: assert property (@(posedge clk)
      rst |=> !sys_clk_disable && !dbgnoc_out_valid)
      else $error("sys_clk_disable or dbgnoc_out_valid high during reset");

endmodule

bind stm_dbgnoc_top stm_assert u_stm_assert (.*);

`default_nettype wire

// File: tests/tb_stm.sv
// Testbench for the STM debug NoC interface
// Clock, reset, LCG trace words and host ready pattern
// Reference packet model, output monitor, register reads, watchdog
`default_nettype none
`timescale 1ns/100ps

module tb_stm import stm_pkg::*; ();

   localparam logic [7:0] CORE_ID = 8'h2c;
   localparam int N_FORMAT = 20;
   localparam int N_BACKP  = 40;
   localparam int N_BURST  = 16;
   localparam int N_MIX    = 20;
   localparam int N_REQ    = 12;
   localparam int TIMEOUT_CYCLES =
      40 * (N_FORMAT + N_BACKP + N_BURST + N_MIX) + 40 * N_REQ + 1000;

   // Host ready patterns
   localparam int READY_HIGH   = 0;
   localparam int READY_RANDOM = 1;
   localparam int READY_LOW    = 2;
   // Packet currently open on the output port
   localparam int KIND_NONE  = 0;
   localparam int KIND_TRACE = 1;
   localparam int KIND_RESP  = 2;

   typedef flit_t [5:0] pkt_t;

   logic   clk;
   logic   rst;
   trace_t trace_in;
   logic   trace_in_valid;
   logic   sys_clk_disable;
   flit_t  dbgnoc_out_flit;
   logic   dbgnoc_out_valid;
   logic   dbgnoc_out_ready;
   flit_t  dbgnoc_in_flit;
   logic   dbgnoc_in_valid;
   logic   dbgnoc_in_ready;

   trace_t      exp_trace_q [$];
   logic [15:0] exp_reg_q [$];
   logic [31:0] word_lcg    = 32'h7a6d;
   logic [31:0] ready_lcg   = 32'h7a6d;
   int          ready_mode  = READY_LOW;
   int          pkt_kind    = KIND_NONE;
   int          flit_idx    = 0;
   int          words_sent  = 0;
   int          error_count = 0;
   pkt_t        cur_pkt;
   logic [15:0] mix_addr [3] = '{16'd0, 16'd1, 16'd5};

   stm_dbgnoc_top #(.CORE_ID(CORE_ID), .TRACE_DEPTH(4), .OUT_DEPTH(6)) u_stm_dbgnoc_top (.*);

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic flit_t make_flit(input logic [1:0] ftype, input logic [15:0] data);
      flit_t f;
      f.ftype = ftype;
      f.data  = data;
      return f;
   endfunction

   // Reference trace packet from header to instruction word
   function automatic pkt_t expected_trace_packet(input trace_t t);
      pkt_t p;
      p[0] = make_flit(FLIT_HEADER, {ADDR_HOST, CLASS_TRACE, CORE_ID});
      p[1] = make_flit(FLIT_PAYLOAD, t.timestamp[31:16]);
      p[2] = make_flit(FLIT_PAYLOAD, t.timestamp[15:0]);
      p[3] = make_flit(FLIT_PAYLOAD, t.reg_value[31:16]);
      p[4] = make_flit(FLIT_PAYLOAD, t.reg_value[15:0]);
      p[5] = make_flit(FLIT_LAST, t.insn);
      return p;
   endfunction

   // Register map with the count valid only after traffic drains
   function automatic logic [15:0] expected_reg(input logic [15:0] addr, input int count);
      case (addr)
         REG_TYPE_VERSION: return 16'h0500;
         REG_CORE_ID:      return {8'h00, CORE_ID};
         REG_TRACE_COUNT:  return 16'(count);
         default:          return 16'h0000;
      endcase
   endfunction

   task automatic report_error(input string msg);
      error_count++;
      $display("** Error at %0t: %s", $time, msg);
      $display("Verification failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_flit(input flit_t got, input flit_t exp, input string what);
      if (got !== exp) begin
         report_error($sformatf("%s: got type %0d data %h, expected type %0d data %h",
                                what, got.ftype, got.data, exp.ftype, exp.data));
      end
   endtask

   task automatic check_reg(input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         report_error($sformatf("register read: got %h, expected %h", got, exp));
      end
   endtask

   task automatic random_word(output trace_t w);
      word_lcg    = lcg_next(word_lcg);
      w.timestamp = word_lcg;
      word_lcg    = lcg_next(word_lcg);
      w.reg_value = word_lcg;
      word_lcg    = lcg_next(word_lcg);
      w.insn      = word_lcg[31:16];
   endtask

   // One word and two idle cycles so the registered disable catches up
   task automatic send_trace(input trace_t w);
      while (sys_clk_disable) @(posedge clk);
      trace_in       <= w;
      trace_in_valid <= 1'b1;
      exp_trace_q.push_back(w);
      words_sent++;
      @(posedge clk);
      trace_in_valid <= 1'b0;
      repeat (2) @(posedge clk);
   endtask

   task automatic send_flit(input flit_t f);
      dbgnoc_in_flit  <= f;
      dbgnoc_in_valid <= 1'b1;
      do @(posedge clk); while (!dbgnoc_in_ready);
      dbgnoc_in_valid <= 1'b0;
   endtask

   // Two-flit read request
   task automatic send_read(input logic [15:0] addr);
      exp_reg_q.push_back(expected_reg(addr, words_sent));
      send_flit(make_flit(FLIT_HEADER, {5'd1, CLASS_CONF_REQ, 8'h00}));
      send_flit(make_flit(FLIT_LAST, addr));
   endtask

   task automatic wait_drain();
      while (exp_trace_q.size() != 0 || exp_reg_q.size() != 0 || pkt_kind != KIND_NONE)
         @(posedge clk);
   endtask

   // Tracks packet boundaries and flags a header inside an open packet
   task automatic take_flit(input flit_t f);
      hdr_t h;
      h = hdr_t'(f.data);
      if (pkt_kind == KIND_NONE) begin
         if (f.ftype != FLIT_HEADER) begin
            report_error("non-header flit outside of a packet");
         end else if (h.cls == CLASS_TRACE && exp_trace_q.size() != 0) begin
            cur_pkt = expected_trace_packet(exp_trace_q.pop_front());
            check_flit(f, cur_pkt[0], "trace header");
            pkt_kind = KIND_TRACE;
            flit_idx = 1;
         end else if (h.cls == CLASS_CONF_RESP && exp_reg_q.size() != 0) begin
            check_flit(f, make_flit(FLIT_HEADER, {ADDR_HOST, CLASS_CONF_RESP, CORE_ID}),
                       "response header");
            pkt_kind = KIND_RESP;
         end else begin
            report_error($sformatf("unexpected packet with class %0d", h.cls));
         end
      end else if (f.ftype == FLIT_HEADER) begin
         report_error("header flit inside an open packet");
      end else if (pkt_kind == KIND_TRACE) begin
         check_flit(f, cur_pkt[flit_idx], $sformatf("trace flit %0d", flit_idx));
         flit_idx++;
         if (flit_idx == 6) pkt_kind = KIND_NONE;
      end else if (f.ftype != FLIT_LAST) begin
         report_error("response packet longer than two flits");
      end else begin
         check_reg(f.data, exp_reg_q.pop_front());
         pkt_kind = KIND_NONE;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Host ready pattern
   always @(posedge clk) begin
      ready_lcg = lcg_next(ready_lcg);
      case (ready_mode)
         READY_HIGH:   dbgnoc_out_ready <= 1'b1;
         READY_RANDOM: dbgnoc_out_ready <= ready_lcg[20];
         default:      dbgnoc_out_ready <= 1'b0;
      endcase
   end

   // Compare every accepted output flit
   always @(posedge clk) begin
      if (!rst && dbgnoc_out_valid && dbgnoc_out_ready) take_flit(dbgnoc_out_flit);
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      trace_t w;
      int     n;
      rst              = 1'b1;
      trace_in         = '0;
      trace_in_valid   = 1'b0;
      dbgnoc_out_ready = 1'b0;
      dbgnoc_in_flit   = '0;
      dbgnoc_in_valid  = 1'b0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      if (!dbgnoc_in_ready || sys_clk_disable || dbgnoc_out_valid)
         report_error("outputs not at their reset values after reset");

      // Packet format with the host always ready
      ready_mode <= READY_HIGH;
      repeat (N_FORMAT) begin
         random_word(w);
         send_trace(w);
      end
      wait_drain();

      // Register reads including an unmapped address
      send_read(REG_TYPE_VERSION);
      send_read(REG_CORE_ID);
      send_read(16'd5);
      wait_drain();
      send_read(REG_TRACE_COUNT);
      wait_drain();

      // Random back-pressure from the host
      ready_mode <= READY_RANDOM;
      repeat (N_BACKP) begin
         random_word(w);
         send_trace(w);
      end
      wait_drain();

      // Stalled port fills the queue until the core is halted
      ready_mode <= READY_LOW;
      n = 0;
      while (!sys_clk_disable && n < N_BURST) begin
         random_word(w);
         send_trace(w);
         n++;
      end
      if (!sys_clk_disable) report_error("sys_clk_disable did not rise with the port stalled");
      repeat (8) @(posedge clk);
      if (!sys_clk_disable) report_error("sys_clk_disable fell while the port was stalled");
      ready_mode <= READY_HIGH;
      wait_drain();
      @(posedge clk);
      if (sys_clk_disable) report_error("sys_clk_disable stayed high after the queue drained");
      send_read(REG_TRACE_COUNT);
      wait_drain();

      // Requests mixed into trace traffic
      ready_mode <= READY_RANDOM;
      fork
         repeat (N_MIX) begin
            random_word(w);
            send_trace(w);
         end
         for (int i = 0; i < 6; i++) begin
            repeat (5 + 3 * i) @(posedge clk);
            send_read(mix_addr[i % 3]);
         end
      join
      wait_drain();
      send_read(REG_TRACE_COUNT);
      wait_drain();

      if (error_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
src/stm_pkg.sv
src/flit_fifo.sv
src/trace_capture.sv
src/trace_packetizer.sv
src/conf_responder.sv
src/noc_out_arbiter.sv
src/stm_dbgnoc_top.sv
tests/stm_assert.sv
tests/tb_stm.sv
